//--- Makefile
VERILATOR := verilator
FLAGS     := --timing --timescale 1ns/10ps
TOP       := cdma_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/cdma_tb.sv
// Central DMA testbench
`timescale 1ns/10ps
`default_nettype none

module cdma_tb;

  localparam int N_OUTSTANDING = 4;
  localparam int TIMEOUT = 2000;
  // Idle cycles that mean the write queue is full
  localparam int STALL_CYCLES = 30;
  localparam int SETTLE_CYCLES = 10;

  logic aclk;
  logic arst_n;
  logic rd_valid;
  logic rd_ready;
  cdma_pkg::addr_t rd_addr;
  cdma_pkg::len_t rd_len;
  logic rd_ctl;
  logic wr_valid;
  logic wr_ready;
  cdma_pkg::addr_t wr_addr;
  cdma_pkg::len_t wr_len;
  logic wr_ctl;
  cdma_pkg::data_t rd_tdata;
  logic rd_tvalid;
  logic rd_tready;
  logic rd_tlast;
  cdma_pkg::data_t wr_tdata;
  logic wr_tvalid;
  logic wr_tready;
  logic rd_done;
  logic wr_done;

  // Beats seen on the read stream, filled by the monitor
  cdma_pkg::data_t beat_data [1024];
  logic beat_lst [1024];
  logic [9:0] beat_wr = '0;
  logic [9:0] rd_idx;
  int rd_done_cnt = 0;
  int wr_done_cnt = 0;

  // Per-run and per-test bookkeeping
  int err_cnt;
  int err_base;
  int pass_cnt;
  int fail_tests;
  int exp_rd;
  int exp_wr;
  int base_rd;
  int base_wr;
  int acc_cnt;
  logic bp_on;
  string tname;
  cdma_pkg::data_t wq [$];
  event abort_ev;

  cdma_top #(
    .N_OUTSTANDING (N_OUTSTANDING)
  ) dut0 (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .rd_addr   (rd_addr),
    .rd_len    (rd_len),
    .rd_ctl    (rd_ctl),
    .wr_valid  (wr_valid),
    .wr_ready  (wr_ready),
    .wr_addr   (wr_addr),
    .wr_len    (wr_len),
    .wr_ctl    (wr_ctl),
    .rd_tdata  (rd_tdata),
    .rd_tvalid (rd_tvalid),
    .rd_tready (rd_tready),
    .rd_tlast  (rd_tlast),
    .wr_tdata  (wr_tdata),
    .wr_tvalid (wr_tvalid),
    .wr_tready (wr_tready),
    .rd_done   (rd_done),
    .wr_done   (wr_done)
  );

  // 8 ns clock
  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  //////////////////////////////
  // Stream and done monitor
  //////////////////////////////

  // Sampled mid-cycle, a transfer follows at the next rising edge
  always @(negedge aclk) begin
    if (arst_n) begin
      if (rd_tvalid && rd_tready) begin
        beat_data[beat_wr] = rd_tdata;
        beat_lst[beat_wr] = rd_tlast;
        beat_wr = beat_wr + 1'b1;
      end
      if (rd_done) begin
        rd_done_cnt++;
      end
      if (wr_done) begin
        wr_done_cnt++;
      end
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  // Ends the run through the main fork
  task automatic abort_run(input string msg);
    $display("%s", msg);
    fail_tests++;
    -> abort_ev;
    @(posedge aclk);
  endtask

  task automatic start_test();
    err_base = err_cnt;
    exp_rd = 0;
    exp_wr = 0;
    base_rd = rd_done_cnt;
    base_wr = wr_done_cnt;
    bp_on = (tname == "backpressure");
  endtask

  task automatic report_test();
    if (err_cnt == err_base) begin
      pass_cnt++;
      $display("test %s: ok", tname);
    end else begin
      fail_tests++;
      $display("test %s: %0d errors", tname, err_cnt - err_base);
    end
  endtask

  // One descriptor on either channel, held until ready
  task automatic issue_desc(input logic is_rd, input cdma_pkg::addr_t addr,
                            input cdma_pkg::len_t len, input logic ctl);
    int wait_cnt;
    @(posedge aclk);
    if (is_rd) begin
      rd_valid <= 1'b1;
      rd_addr <= addr;
      rd_len <= len;
      rd_ctl <= ctl;
    end else begin
      wr_valid <= 1'b1;
      wr_addr <= addr;
      wr_len <= len;
      wr_ctl <= ctl;
    end
    wait_cnt = 0;
    @(negedge aclk);
    while (!(is_rd ? rd_ready : wr_ready)) begin
      if (wait_cnt == TIMEOUT) begin
        if (is_rd) abort_run("timeout waiting for rd_ready");
        else abort_run("timeout waiting for wr_ready");
      end
      wait_cnt++;
      @(negedge aclk);
    end
    @(posedge aclk);
    if (is_rd) begin
      rd_valid <= 1'b0;
    end else begin
      wr_valid <= 1'b0;
      acc_cnt++;
    end
  endtask

  // Write stream from wq, one word per handshake
  task automatic send_stream();
    int wait_cnt;
    foreach (wq[i]) begin
      @(posedge aclk);
      wr_tvalid <= 1'b1;
      wr_tdata <= wq[i];
      wait_cnt = 0;
      @(negedge aclk);
      while (!wr_tready) begin
        if (wait_cnt == TIMEOUT) abort_run("timeout waiting for wr_tready");
        wait_cnt++;
        @(negedge aclk);
      end
    end
    @(posedge aclk);
    wr_tvalid <= 1'b0;
  endtask

  // Expected beats in wq, last only at the end of a ctl=1 descriptor
  task automatic collect_beats(input logic ctl);
    int wait_cnt;
    logic [31:0] rnd;
    logic exp_last;
    foreach (wq[i]) begin
      wait_cnt = 0;
      while (beat_wr == rd_idx) begin
        if (wait_cnt == TIMEOUT) abort_run("timeout waiting for rd_tvalid");
        wait_cnt++;
        @(posedge aclk);
        if (bp_on) begin
          rnd = $urandom;
          rd_tready <= rnd[0];
        end
      end
      exp_last = ctl && (i == wq.size() - 1);
      check_value("rd_tdata", wq[i], beat_data[rd_idx]);
      check_value("rd_tlast", {31'd0, exp_last}, {31'd0, beat_lst[rd_idx]});
      rd_idx = rd_idx + 1'b1;
    end
    if (bp_on) begin
      @(posedge aclk);
      rd_tready <= 1'b1;
    end
  endtask

  // Descriptors of 2 words at 0x200 up, ctl set on odd ones
  task automatic queue_test(input int count);
    int j;
    int k;
    int idle;
    int guard;
    int seen;
    logic [31:0] a;
    acc_cnt = 0;
    for (j = 0; j < count; j++) begin
      if (j % 2 == 1) exp_wr++;
    end
    fork
      begin
        for (j = 0; j < count; j++) begin
          a = 32'h200 + 2 * j;
          issue_desc(1'b0, a[9:0], 8'd2, j[0]);
        end
      end
      begin
        idle = 0;
        guard = 0;
        seen = 0;
        // No stream data yet, wait for the queue to fill
        while (idle < STALL_CYCLES && acc_cnt < count) begin
          if (guard == TIMEOUT) abort_run("timeout waiting for the write queue to fill");
          guard++;
          @(posedge aclk);
          if (acc_cnt != seen) begin
            seen = acc_cnt;
            idle = 0;
          end else begin
            idle++;
          end
        end
        $display("write queue took %0d descriptors before stalling", acc_cnt);
        check_value("accepts >= N_OUTSTANDING", 32'd1, {31'd0, acc_cnt >= N_OUTSTANDING});
        check_value("accepts < N_OUTSTANDING+2", 32'd1, {31'd0, acc_cnt < N_OUTSTANDING + 2});
        wq.delete();
        for (k = 0; k < 2 * count; k++) begin
          wq.push_back(32'hd00d0200 + k);
        end
        send_stream();
      end
    join
  endtask

  task automatic finish_test();
    int wait_cnt;
    wait_cnt = 0;
    while ((rd_done_cnt - base_rd) < exp_rd || (wr_done_cnt - base_wr) < exp_wr) begin
      if (wait_cnt == TIMEOUT) abort_run("timeout waiting for rd_done and wr_done");
      wait_cnt++;
      @(posedge aclk);
    end
    // Catch stray pulses or beats
    repeat (SETTLE_CYCLES) @(posedge aclk);
    check_value("rd_done count", exp_rd, rd_done_cnt - base_rd);
    check_value("wr_done count", exp_wr, wr_done_cnt - base_wr);
    check_value("extra rd beats", 32'd0, {22'd0, beat_wr - rd_idx});
    report_test();
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  task automatic run_tests();
    int fd;
    int code;
    int ch;
    int n;
    int j;
    string cmd;
    logic [31:0] a;
    logic [31:0] l;
    logic [31:0] c;
    logic [31:0] w;
    repeat (16) @(posedge aclk);
    arst_n <= 1'b1;
    // First cycle out of reset
    tname = "reset";
    start_test();
    @(negedge aclk);
    check_value("rd_tvalid", 32'd0, {31'd0, rd_tvalid});
    check_value("wr_tready", 32'd0, {31'd0, wr_tready});
    check_value("rd_done", 32'd0, {31'd0, rd_done});
    check_value("wr_done", 32'd0, {31'd0, wr_done});
    check_value("rd_ready", 32'd0, {31'd0, rd_ready});
    check_value("wr_ready", 32'd0, {31'd0, wr_ready});
    report_test();
    @(posedge aclk);
    rd_tready <= 1'b1;
    fd = $fopen("sim/cdma_tests.txt", "r");
    if (fd == 0) abort_run("cannot open sim/cdma_tests.txt");
    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd == "#") begin
        ch = 0;
        while (ch != 10 && ch != -1) ch = $fgetc(fd);
      end else if (cmd == "T") begin
        code = $fscanf(fd, "%s", tname);
        start_test();
      end else if (cmd == "W" || cmd == "R") begin
        code = $fscanf(fd, "%h %h %h", a, l, c);
        wq.delete();
        for (j = 0; j < l; j++) begin
          code = $fscanf(fd, "%h", w);
          wq.push_back(w);
        end
        if (cmd == "W") begin
          if (c[0]) exp_wr++;
          issue_desc(1'b0, a[9:0], l[7:0], c[0]);
          send_stream();
        end else begin
          if (c[0]) exp_rd++;
          issue_desc(1'b1, a[9:0], l[7:0], c[0]);
          collect_beats(c[0]);
        end
      end else if (cmd == "F") begin
        code = $fscanf(fd, "%d", n);
        queue_test(n);
      end else if (cmd == "E") begin
        finish_test();
      end else begin
        abort_run("unknown command in sim/cdma_tests.txt");
      end
    end
    $fclose(fd);
  endtask

  initial begin
    arst_n = 1'b0;
    rd_valid = 1'b0;
    rd_addr = '0;
    rd_len = '0;
    rd_ctl = 1'b0;
    wr_valid = 1'b0;
    wr_addr = '0;
    wr_len = '0;
    wr_ctl = 1'b0;
    rd_tready = 1'b0;
    wr_tdata = '0;
    wr_tvalid = 1'b0;
    rd_idx = '0;
    bp_on = 1'b0;
    err_cnt = 0;
    pass_cnt = 0;
    fail_tests = 0;
    void'($urandom(32'hfe24));
    fork
      run_tests();
      @(abort_ev);
    join_any
    $display("tests: %0d passed, %0d failed", pass_cnt, fail_tests);
    if (fail_tests == 0 && err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/cdma_tests.txt
# T name | W addr len ctl words | R addr len ctl expected words (hex fields)
# F count of write descriptors queued without data | E ends a test
T single
W 010 4 1 11111111 22222222 33333333 44444444
R 010 4 1 11111111 22222222 33333333 44444444
E
T grouped
W 040 2 0 a0000040 a0000041
W 042 3 0 b0000042 b0000043 b0000044
W 045 1 1 c0000045
R 040 2 0 a0000040 a0000041
R 042 3 0 b0000042 b0000043 b0000044
R 045 1 1 c0000045
E
T span
R 040 6 1 a0000040 a0000041 b0000042 b0000043 b0000044 c0000045
E
T backpressure
W 100 8 1 5a5a0100 a5a50101 0f0f0102 f0f00103 12340104 56780105 9abc0106 def00107
R 100 8 1 5a5a0100 a5a50101 0f0f0102 f0f00103 12340104 56780105 9abc0106 def00107
E
T backpressure
W 180 3 0 01020180 03040181 05060182
R 180 3 1 01020180 03040181 05060182
E
T queue
F 6
R 200 6 1 d00d0200 d00d0201 d00d0202 d00d0203 d00d0204 d00d0205
E
T readback
R 010 4 0 11111111 22222222 33333333 44444444
R 206 6 1 d00d0206 d00d0207 d00d0208 d00d0209 d00d020a d00d020b
E

//--- src/cdma_pkg.sv
// Central DMA shared definitions
`default_nettype none

package cdma_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Word address into the on-chip memory
  localparam int ADDR_BITS = 10;
  // One stream or memory word
  localparam int DATA_BITS = 32;
  // Descriptor length in words, zero never issued
  localparam int LEN_BITS = 8;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [DATA_BITS-1:0] data_t;
  typedef logic [LEN_BITS-1:0] len_t;

  // Shared by read and write engines
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } engine_state_t;

endpackage

`default_nettype wire

//--- src/cdma_top.sv
// Central DMA top level
`timescale 1ns/10ps
`default_nettype none

module cdma_top #(
  parameter int N_OUTSTANDING = 4
) (
  input  wire                    aclk,
  input  wire                    arst_n,
  // Read descriptor
  input  wire                    rd_valid,
  output logic                   rd_ready,
  input  wire cdma_pkg::addr_t   rd_addr,
  input  wire cdma_pkg::len_t    rd_len,
  input  wire                    rd_ctl,
  // Write descriptor
  input  wire                    wr_valid,
  output logic                   wr_ready,
  input  wire cdma_pkg::addr_t   wr_addr,
  input  wire cdma_pkg::len_t    wr_len,
  input  wire                    wr_ctl,
  // Read stream out
  output cdma_pkg::data_t        rd_tdata,
  output logic                   rd_tvalid,
  input  wire                    rd_tready,
  output logic                   rd_tlast,
  // Write stream in
  input  wire cdma_pkg::data_t   wr_tdata,
  input  wire                    wr_tvalid,
  output logic                   wr_tready,
  // Completion
  output logic                   rd_done,
  output logic                   wr_done
);

  // Sequencer to engine
  logic rd_eng_valid;
  logic rd_eng_ready;
  cdma_pkg::addr_t rd_eng_addr;
  cdma_pkg::len_t rd_eng_len;
  logic rd_eng_done;
  logic rd_beat_last;
  logic wr_eng_valid;
  logic wr_eng_ready;
  cdma_pkg::addr_t wr_eng_addr;
  cdma_pkg::len_t wr_eng_len;
  logic wr_eng_done;

  // Engine to memory
  logic mem_ren;
  cdma_pkg::addr_t mem_raddr;
  cdma_pkg::data_t mem_rdata;
  logic mem_wen;
  cdma_pkg::addr_t mem_waddr;
  cdma_pkg::data_t mem_wdata;

  //////////////////////////////
  // Read channel
  //////////////////////////////

  desc_sequencer #(
    .QDEPTH (N_OUTSTANDING)
  ) rd_seq0 (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .s_valid   (rd_valid),
    .s_ready   (rd_ready),
    .s_addr    (rd_addr),
    .s_len     (rd_len),
    .s_ctl     (rd_ctl),
    .eng_valid (rd_eng_valid),
    .eng_ready (rd_eng_ready),
    .eng_addr  (rd_eng_addr),
    .eng_len   (rd_eng_len),
    .eng_done  (rd_eng_done),
    .beat_last (rd_beat_last),
    .done      (rd_done),
    .last      (rd_tlast)
  );

  dma_rd_engine rd_eng0 (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .desc_valid (rd_eng_valid),
    .desc_ready (rd_eng_ready),
    .desc_addr  (rd_eng_addr),
    .desc_len   (rd_eng_len),
    .mem_ren    (mem_ren),
    .mem_raddr  (mem_raddr),
    .mem_rdata  (mem_rdata),
    .tdata      (rd_tdata),
    .tvalid     (rd_tvalid),
    .tready     (rd_tready),
    .beat_last  (rd_beat_last),
    .eng_done   (rd_eng_done)
  );

  //////////////////////////////
  // Write channel
  //////////////////////////////

  // Write stream has no last flag
  desc_sequencer #(
    .QDEPTH (N_OUTSTANDING)
  ) wr_seq0 (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .s_valid   (wr_valid),
    .s_ready   (wr_ready),
    .s_addr    (wr_addr),
    .s_len     (wr_len),
    .s_ctl     (wr_ctl),
    .eng_valid (wr_eng_valid),
    .eng_ready (wr_eng_ready),
    .eng_addr  (wr_eng_addr),
    .eng_len   (wr_eng_len),
    .eng_done  (wr_eng_done),
    .beat_last (1'b0),
    .done      (wr_done),
    .last      ()
  );

  dma_wr_engine wr_eng0 (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .desc_valid (wr_eng_valid),
    .desc_ready (wr_eng_ready),
    .desc_addr  (wr_eng_addr),
    .desc_len   (wr_eng_len),
    .tdata      (wr_tdata),
    .tvalid     (wr_tvalid),
    .tready     (wr_tready),
    .mem_wen    (mem_wen),
    .mem_waddr  (mem_waddr),
    .mem_wdata  (mem_wdata),
    .eng_done   (wr_eng_done)
  );

  //////////////////////////////
  // Shared memory
  //////////////////////////////

  dma_word_mem mem0 (
    .aclk  (aclk),
    .wen   (mem_wen),
    .waddr (mem_waddr),
    .wdata (mem_wdata),
    .ren   (mem_ren),
    .raddr (mem_raddr),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

//--- src/desc_fifo.sv
// Valid/ready descriptor FIFO
`timescale 1ns/10ps
`default_nettype none

module desc_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  wire              aclk,
  input  wire              arst_n,
  input  wire              in_valid,
  output logic             in_ready,
  input  wire [WIDTH-1:0]  in_data,
  output logic             out_valid,
  input  wire              out_ready,
  output logic [WIDTH-1:0] out_data
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);
  localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);
  localparam logic [CNT_BITS-1:0] FULL_CNT = CNT_BITS'(DEPTH);

  // Storage, payload only
  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic [CNT_BITS-1:0] count_nxt;
  logic push;
  logic pop;

  assign push = in_valid & in_ready;
  assign pop = out_valid & out_ready;

  // First-word fall-through head
  assign out_valid = (count != '0);
  assign out_data = mem[rd_ptr];

  // Occupancy after this edge
  always_comb begin
    case ({push, pop})
      2'b10:   count_nxt = count + 1'b1;
      2'b01:   count_nxt = count - 1'b1;
      default: count_nxt = count;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap at DEPTH, need not be a power of two
  // Ready registered so it stays low in the first cycle out of reset
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      count    <= count_nxt;
      in_ready <= (count_nxt != FULL_CNT);
    end
  end

endmodule

`default_nettype wire

//--- src/desc_sequencer.sv
// Per-channel descriptor sequencer
`timescale 1ns/10ps
`default_nettype none

module desc_sequencer #(
  parameter int QDEPTH = 4
) (
  input  wire                    aclk,
  input  wire                    arst_n,
  // Descriptor in
  input  wire                    s_valid,
  output logic                   s_ready,
  input  wire cdma_pkg::addr_t   s_addr,
  input  wire cdma_pkg::len_t    s_len,
  input  wire                    s_ctl,
  // Descriptor to engine
  output logic                   eng_valid,
  input  wire                    eng_ready,
  output cdma_pkg::addr_t        eng_addr,
  output cdma_pkg::len_t         eng_len,
  // Engine status
  input  wire                    eng_done,
  input  wire                    beat_last,
  // Gated completion
  output logic                   done,
  output logic                   last
);

  // Packed as {addr, len, ctl}
  localparam int DESC_BITS = cdma_pkg::ADDR_BITS + cdma_pkg::LEN_BITS + 1;

  logic [DESC_BITS-1:0] q_data;
  logic q_valid;
  logic q_ready;
  logic q_ctl;
  logic ctl_push;
  logic ctl_room;
  logic ctl_valid;
  logic ctl_head;

  //////////////////////////////
  // Descriptor queue
  //////////////////////////////

  desc_fifo #(
    .WIDTH (DESC_BITS),
    .DEPTH (QDEPTH)
  ) desc_q0 (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_valid  (s_valid),
    .in_ready  (s_ready),
    .in_data   ({s_addr, s_len, s_ctl}),
    .out_valid (q_valid),
    .out_ready (q_ready),
    .out_data  (q_data)
  );

  assign {eng_addr, eng_len, q_ctl} = q_data;

  // Forward only if the ctl queue can take the bit too
  assign eng_valid = q_valid & ctl_room;
  assign q_ready = eng_ready & ctl_room;
  assign ctl_push = eng_valid & eng_ready;

  //////////////////////////////
  // Control-bit queue
  //////////////////////////////

  // Head is the ctl of the descriptor now in the engine
  desc_fifo #(
    .WIDTH (1),
    .DEPTH (QDEPTH)
  ) ctl_q0 (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_valid  (ctl_push),
    .in_ready  (ctl_room),
    .in_data   (q_ctl),
    .out_valid (ctl_valid),
    .out_ready (eng_done),
    .out_data  (ctl_head)
  );

  // Engines finish in order, so head ctl marks the transfer end
  assign done = eng_done & ctl_valid & ctl_head;
  assign last = beat_last & ctl_valid & ctl_head;

endmodule

`default_nettype wire

//--- src/dma_rd_engine.sv
// DMA read engine
`timescale 1ns/10ps
`default_nettype none

module dma_rd_engine (
  input  wire                    aclk,
  input  wire                    arst_n,
  // Descriptor
  input  wire                    desc_valid,
  output logic                   desc_ready,
  input  wire cdma_pkg::addr_t   desc_addr,
  input  wire cdma_pkg::len_t    desc_len,
  // Memory read port
  output logic                   mem_ren,
  output cdma_pkg::addr_t        mem_raddr,
  input  wire cdma_pkg::data_t   mem_rdata,
  // Stream out
  output cdma_pkg::data_t        tdata,
  output logic                   tvalid,
  input  wire                    tready,
  output logic                   beat_last,
  output logic                   eng_done
);

  cdma_pkg::engine_state_t state;
  cdma_pkg::addr_t rd_addr;
  // Reads left to issue
  cdma_pkg::len_t issue_cnt;
  // Beats left to hand out
  cdma_pkg::len_t beat_cnt;
  logic rd_pend;
  logic out_free;
  logic load;
  logic beat_xfer;

  assign desc_ready = (state == cdma_pkg::IDLE);
  assign eng_done = (state == cdma_pkg::DONE);

  // Output register empties at this edge
  assign out_free = ~tvalid | tready;
  assign beat_xfer = tvalid & tready;

  // No read while the output beat is stalled
  assign mem_ren = (state == cdma_pkg::RUN) && (issue_cnt != '0) && out_free;
  assign mem_raddr = rd_addr;

  // Memory data moves to the output register
  assign load = rd_pend & out_free;

  assign beat_last = tvalid & (beat_cnt == cdma_pkg::len_t'(1));

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= cdma_pkg::IDLE;
      rd_addr   <= '0;
      issue_cnt <= '0;
      beat_cnt  <= '0;
    end else begin
      case (state)
        cdma_pkg::IDLE: begin
          if (desc_valid && desc_ready) begin
            rd_addr   <= desc_addr;
            issue_cnt <= desc_len;
            beat_cnt  <= desc_len;
            state     <= cdma_pkg::RUN;
          end
        end
        cdma_pkg::RUN: begin
          if (mem_ren) begin
            rd_addr   <= rd_addr + 1'b1;
            issue_cnt <= issue_cnt - 1'b1;
          end
          // Final beat out ends the descriptor
          if (beat_xfer) begin
            beat_cnt <= beat_cnt - 1'b1;
            if (beat_cnt == cdma_pkg::len_t'(1)) begin
              state <= cdma_pkg::DONE;
            end
          end
        end
        // One-cycle done pulse
        cdma_pkg::DONE: state <= cdma_pkg::IDLE;
        default: state <= cdma_pkg::IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Output stage
  //////////////////////////////

  // rd_pend set while memory rdata holds an unconsumed word
  // Memory keeps rdata when ren is low, so a stalled word waits there
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      rd_pend <= 1'b0;
      tvalid  <= 1'b0;
    end else begin
      if (mem_ren) begin
        rd_pend <= 1'b1;
      end else if (load) begin
        rd_pend <= 1'b0;
      end
      if (load) begin
        tvalid <= 1'b1;
      end else if (tready) begin
        tvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      tdata <= mem_rdata;
    end
  end

endmodule

`default_nettype wire

//--- src/dma_word_mem.sv
// Dual-port word memory
`timescale 1ns/10ps
`default_nettype none

module dma_word_mem (
  input  wire                    aclk,
  // Write port
  input  wire                    wen,
  input  wire cdma_pkg::addr_t   waddr,
  input  wire cdma_pkg::data_t   wdata,
  // Read port
  input  wire                    ren,
  input  wire cdma_pkg::addr_t   raddr,
  output cdma_pkg::data_t        rdata
);

  localparam int WORDS = 2 ** cdma_pkg::ADDR_BITS;

  cdma_pkg::data_t mem [WORDS];

  always_ff @(posedge aclk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  // One-cycle read, rdata holds while ren is low
  always_ff @(posedge aclk) begin
    if (ren) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

//--- src/dma_wr_engine.sv
// DMA write engine
`timescale 1ns/10ps
`default_nettype none

module dma_wr_engine (
  input  wire                    aclk,
  input  wire                    arst_n,
  // Descriptor
  input  wire                    desc_valid,
  output logic                   desc_ready,
  input  wire cdma_pkg::addr_t   desc_addr,
  input  wire cdma_pkg::len_t    desc_len,
  // Stream in
  input  wire cdma_pkg::data_t   tdata,
  input  wire                    tvalid,
  output logic                   tready,
  // Memory write port
  output logic                   mem_wen,
  output cdma_pkg::addr_t        mem_waddr,
  output cdma_pkg::data_t        mem_wdata,
  output logic                   eng_done
);

  cdma_pkg::engine_state_t state;
  cdma_pkg::addr_t wr_addr;
  // Words still expected
  cdma_pkg::len_t word_cnt;
  logic accept;

  assign desc_ready = (state == cdma_pkg::IDLE);
  assign eng_done = (state == cdma_pkg::DONE);

  // Take a word every cycle in RUN
  assign tready = (state == cdma_pkg::RUN);
  assign accept = tvalid & tready;

  // Accepted word goes to memory in the same cycle
  assign mem_wen = accept;
  assign mem_waddr = wr_addr;
  assign mem_wdata = tdata;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= cdma_pkg::IDLE;
      wr_addr  <= '0;
      word_cnt <= '0;
    end else begin
      case (state)
        cdma_pkg::IDLE: begin
          if (desc_valid && desc_ready) begin
            wr_addr  <= desc_addr;
            word_cnt <= desc_len;
            state    <= cdma_pkg::RUN;
          end
        end
        // Stalled stream just waits here
        cdma_pkg::RUN: begin
          if (accept) begin
            wr_addr  <= wr_addr + 1'b1;
            word_cnt <= word_cnt - 1'b1;
            if (word_cnt == cdma_pkg::len_t'(1)) begin
              state <= cdma_pkg::DONE;
            end
          end
        end
        cdma_pkg::DONE: state <= cdma_pkg::IDLE;
        default: state <= cdma_pkg::IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
src/cdma_pkg.sv
src/desc_fifo.sv
src/desc_sequencer.sv
src/dma_rd_engine.sv
src/dma_wr_engine.sv
src/dma_word_mem.sv
src/cdma_top.sv
sim/cdma_tb.sv
